/* pipe_settings.svh */
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Data path and address width
`define XLEN 32

// Register file
`define REG_ADDR_W 5
`define REG_COUNT (1 << `REG_ADDR_W)

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Byte distance between consecutive instructions
`define PC_STEP 4

`endif

/* isa_pkg.sv */
`include "pipe_settings.svh"

package isa_pkg;

  typedef enum logic [5:0] {
    OPC_RTYPE = 6'h00,
    OPC_ADDI  = 6'h08,
    OPC_LW    = 6'h23,
    OPC_SW    = 6'h2b
  } opcode_e;

  // Function field of register-register operations
  typedef enum logic [5:0] {
    FN_ADD  = 6'h20,
    FN_SUB  = 6'h22,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLT  = 3'd5,
    ALU_SLTU = 3'd6
  } alu_op_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             pad;
    funct_e                 funct;
  } r_fields_t;

  typedef struct packed {
    opcode_e                opcode;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [15:0]            imm;
  } i_fields_t;

  // Same word, register or immediate layout
  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } inst_u;

endpackage

/* pipe_pkg.sv */
`include "pipe_settings.svh"

package pipe_pkg;

  // Where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_RF = 2'd0,
    FWD_EX = 2'd1,
    FWD_WB = 2'd2
  } fwd_e;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                   valid;
    isa_pkg::alu_op_e       alu_op;
    logic                   use_imm;
    logic                   load;
    logic                   store;
    logic                   dest_valid;
    logic [`XLEN-1:0]       a_val;
    logic [`XLEN-1:0]       b_val;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       imm;
    fwd_e                   fwd_a;
    fwd_e                   fwd_b;
  } id_ex_t;

  typedef struct packed {
    logic                   load;
    logic                   store;
    logic                   dest_valid;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                   dest_valid;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       result;
  } mem_wb_t;

endpackage

/* fetch_stage.sv */
`include "pipe_settings.svh"

module fetch_stage import pipe_pkg::*; (
  input  logic             clock,
  input  logic             rst_i,
  output logic [`XLEN-1:0] icache_addr_o,
  output logic             icache_rd_o,
  input  logic [`XLEN-1:0] icache_data_i,
  input  logic             icache_waitrequest_i,
  input  logic             hold_i,
  input  logic             mem_stall_i,
  output if_id_t           if_id_o
);

  logic [`XLEN-1:0] pc_q;
  logic             rd_q;
  logic             fetch_done;
  if_id_t           if_id_q;

  assign icache_addr_o = pc_q;
  assign icache_rd_o   = rd_q;
  assign if_id_o       = if_id_q;

  // Word only taken when nothing downstream is frozen
  assign fetch_done = rd_q & ~icache_waitrequest_i & ~hold_i & ~mem_stall_i;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      pc_q <= `RESET_PC;
      rd_q <= 1'b0;
    end else begin
      rd_q <= 1'b1;
      if (fetch_done) begin
        pc_q <= pc_q + `XLEN'(`PC_STEP);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      if_id_q.valid <= 1'b0;
    end else if (fetch_done) begin
      if_id_q.valid <= 1'b1;
      if_id_q.instr <= icache_data_i;
    end else if (!hold_i && !mem_stall_i) begin
      // Cache still busy
      if_id_q.valid <= 1'b0;
    end
  end

  a_icache_addr_stable: assert property (@(posedge clock) disable iff (rst_i)
    icache_rd_o && icache_waitrequest_i |=> $stable(icache_addr_o));

endmodule

/* decode_stage.sv */
`include "pipe_settings.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_i,
  input  if_id_t                 if_id_i,
  output logic [`REG_ADDR_W-1:0] rfile_rd_addr1_o,
  output logic [`REG_ADDR_W-1:0] rfile_rd_addr2_o,
  input  logic [`XLEN-1:0]       rfile_rd_data1_i,
  input  logic [`XLEN-1:0]       rfile_rd_data2_i,
  input  ex_mem_t                ex_mem_i,
  input  logic                   mem_stall_i,
  output logic                   hold_o,
  output id_ex_t                 id_ex_o
);

  inst_u                  inst;
  logic                   known;
  logic                   uses_rt;
  logic                   has_dest;
  logic                   is_load;
  logic                   is_store;
  logic                   use_imm;
  alu_op_e                alu_op;
  logic [`REG_ADDR_W-1:0] dest;
  logic                   take;
  id_ex_t                 id_ex_d;
  id_ex_t                 id_ex_q;

  // Younger producer wins: decode/execute first, then execute/memory
  function automatic fwd_e fwd_select(input logic [`REG_ADDR_W-1:0] src,
                                      input id_ex_t ie, input ex_mem_t em);
    if (ie.dest_valid && ie.dest == src) begin
      return FWD_EX;
    end else if (em.dest_valid && em.dest == src) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign inst             = if_id_i.instr;
  assign rfile_rd_addr1_o = inst.r_fields.rs;
  assign rfile_rd_addr2_o = inst.r_fields.rt;

  always_comb begin
    known    = 1'b1;
    uses_rt  = 1'b0;
    has_dest = 1'b1;
    is_load  = 1'b0;
    is_store = 1'b0;
    use_imm  = 1'b1;
    alu_op   = ALU_ADD;
    dest     = inst.i_fields.rt;
    case (inst.r_fields.opcode)
      OPC_RTYPE: begin
        uses_rt = 1'b1;
        use_imm = 1'b0;
        dest    = inst.r_fields.rd;
        case (inst.r_fields.funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          default: known = 1'b0;
        endcase
      end
      OPC_ADDI: alu_op = ALU_ADD;
      OPC_LW:   is_load = 1'b1;
      OPC_SW: begin
        is_store = 1'b1;
        uses_rt  = 1'b1;
        has_dest = 1'b0;
      end
      default: known = 1'b0;
    endcase
  end

  // Load in decode/execute feeding this instruction
  assign hold_o = if_id_i.valid & known & id_ex_q.load & id_ex_q.dest_valid &
                  ((id_ex_q.dest == inst.i_fields.rs) |
                   (uses_rt & (id_ex_q.dest == inst.i_fields.rt)));

  assign take = if_id_i.valid & known & ~hold_o;

  always_comb begin
    id_ex_d.valid      = take;
    id_ex_d.alu_op     = alu_op;
    id_ex_d.use_imm    = use_imm;
    id_ex_d.load       = take & is_load;
    id_ex_d.store      = take & is_store;
    id_ex_d.dest_valid = take & has_dest & (dest != '0);
    id_ex_d.a_val      = rfile_rd_data1_i;
    id_ex_d.b_val      = rfile_rd_data2_i;
    id_ex_d.rs         = inst.i_fields.rs;
    id_ex_d.rt         = inst.i_fields.rt;
    id_ex_d.dest       = dest;
    id_ex_d.imm        = {{(`XLEN-16){inst.i_fields.imm[15]}}, inst.i_fields.imm};
    id_ex_d.fwd_a      = fwd_select(inst.i_fields.rs, id_ex_q, ex_mem_i);
    id_ex_d.fwd_b      = uses_rt ? fwd_select(inst.i_fields.rt, id_ex_q, ex_mem_i) : FWD_RF;
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      id_ex_q.valid      <= 1'b0;
      id_ex_q.load       <= 1'b0;
      id_ex_q.store      <= 1'b0;
      id_ex_q.dest_valid <= 1'b0;
    end else if (!mem_stall_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

  a_no_dest_r0: assert property (@(posedge clock) disable iff (rst_i)
    ex_mem_i.dest_valid |-> ex_mem_i.dest != '0);

endmodule

/* execute_stage.sv */
`include "pipe_settings.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic    clock,
  input  logic    rst_i,
  input  id_ex_t  id_ex_i,
  input  mem_wb_t mem_wb_i,
  input  logic    mem_stall_i,
  output ex_mem_t ex_mem_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_res;
  ex_mem_t          ex_mem_q;

  function automatic logic [`XLEN-1:0] operand(input fwd_e sel,
                                               input logic [`XLEN-1:0] rf_val,
                                               input logic [`XLEN-1:0] ex_val,
                                               input logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_EX:  return ex_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  assign op_a  = operand(id_ex_i.fwd_a, id_ex_i.a_val, ex_mem_q.result, mem_wb_i.result);
  assign op_b  = operand(id_ex_i.fwd_b, id_ex_i.b_val, ex_mem_q.result, mem_wb_i.result);
  assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : op_b;

  // Loads and stores go through ALU_ADD for the address
  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB:  alu_res = op_a - alu_b;
      ALU_AND:  alu_res = op_a & alu_b;
      ALU_OR:   alu_res = op_a | alu_b;
      ALU_XOR:  alu_res = op_a ^ alu_b;
      ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op_a < alu_b};
      default:  alu_res = op_a + alu_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      ex_mem_q.load       <= 1'b0;
      ex_mem_q.store      <= 1'b0;
      ex_mem_q.dest_valid <= 1'b0;
    end else if (!mem_stall_i) begin
      ex_mem_q.load       <= id_ex_i.load;
      ex_mem_q.store      <= id_ex_i.store;
      ex_mem_q.dest_valid <= id_ex_i.dest_valid;
      ex_mem_q.dest       <= id_ex_i.dest;
      ex_mem_q.result     <= alu_res;
      ex_mem_q.store_data <= op_b;
    end
  end

  assign ex_mem_o = ex_mem_q;

  // Selects chosen in decode must still match the producers here
  a_fwd_a_ex: assert property (@(posedge clock) disable iff (rst_i)
    id_ex_i.valid && id_ex_i.fwd_a == FWD_EX |->
      ex_mem_q.dest_valid && !ex_mem_q.load && ex_mem_q.dest == id_ex_i.rs);

  a_fwd_b_ex: assert property (@(posedge clock) disable iff (rst_i)
    id_ex_i.valid && id_ex_i.fwd_b == FWD_EX |->
      ex_mem_q.dest_valid && !ex_mem_q.load && ex_mem_q.dest == id_ex_i.rt);

endmodule

/* memory_stage.sv */
`include "pipe_settings.svh"

module memory_stage import pipe_pkg::*; (
  input  logic             clock,
  input  logic             rst_i,
  input  ex_mem_t          ex_mem_i,
  output logic [`XLEN-1:0] dcache_addr_o,
  output logic [`XLEN-1:0] dcache_wr_data_o,
  input  logic [`XLEN-1:0] dcache_data_i,
  output logic             dcache_rd_o,
  output logic             dcache_wr_o,
  input  logic             dcache_waitrequest_i,
  output logic             mem_stall_o,
  output mem_wb_t          mem_wb_o
);

  logic    access;
  mem_wb_t mem_wb_q;

  assign access           = ex_mem_i.load | ex_mem_i.store;
  assign dcache_addr_o    = {ex_mem_i.result[`XLEN-1:2], 2'b00};
  assign dcache_wr_data_o = ex_mem_i.store_data;
  assign dcache_rd_o      = ex_mem_i.load;
  assign dcache_wr_o      = ex_mem_i.store;
  assign mem_stall_o      = access & dcache_waitrequest_i;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      mem_wb_q.dest_valid <= 1'b0;
    end else if (mem_stall_o) begin
      // Write enable dropped, result and index stay for forwarding
      mem_wb_q.dest_valid <= 1'b0;
    end else begin
      mem_wb_q.dest_valid <= ex_mem_i.dest_valid;
      mem_wb_q.dest       <= ex_mem_i.dest;
      mem_wb_q.result     <= ex_mem_i.load ? dcache_data_i : ex_mem_i.result;
    end
  end

  assign mem_wb_o = mem_wb_q;

  a_rd_wr_onehot: assert property (@(posedge clock) disable iff (rst_i)
    !(dcache_rd_o && dcache_wr_o));

  a_req_stable: assert property (@(posedge clock) disable iff (rst_i)
    access && dcache_waitrequest_i |=>
      $stable(dcache_addr_o) && $stable(dcache_wr_data_o) &&
      $stable(dcache_rd_o) && $stable(dcache_wr_o));

endmodule

/* pipeline.sv */
`include "pipe_settings.svh"

module pipeline import pipe_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_i,
  output logic [`XLEN-1:0]       icache_addr_o,
  output logic                   icache_rd_o,
  input  logic [`XLEN-1:0]       icache_data_i,
  input  logic                   icache_waitrequest_i,
  output logic [`REG_ADDR_W-1:0] rfile_rd_addr1_o,
  output logic [`REG_ADDR_W-1:0] rfile_rd_addr2_o,
  input  logic [`XLEN-1:0]       rfile_rd_data1_i,
  input  logic [`XLEN-1:0]       rfile_rd_data2_i,
  output logic [`XLEN-1:0]       dcache_addr_o,
  output logic                   dcache_rd_o,
  output logic                   dcache_wr_o,
  output logic [`XLEN-1:0]       dcache_wr_data_o,
  input  logic [`XLEN-1:0]       dcache_data_i,
  input  logic                   dcache_waitrequest_i,
  output logic [`REG_ADDR_W-1:0] rfile_wr_addr_o,
  output logic                   rfile_wr_en_o,
  output logic [`XLEN-1:0]       rfile_wr_data_o
);

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;
  logic    hold;
  logic    mem_stall;

  fetch_stage fetch0 (
    .clock                (clock),
    .rst_i                (rst_i),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .hold_i               (hold),
    .mem_stall_i          (mem_stall),
    .if_id_o              (if_id)
  );

  decode_stage decode0 (
    .clock            (clock),
    .rst_i            (rst_i),
    .if_id_i          (if_id),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .ex_mem_i         (ex_mem),
    .mem_stall_i      (mem_stall),
    .hold_o           (hold),
    .id_ex_o          (id_ex)
  );

  execute_stage execute0 (
    .clock       (clock),
    .rst_i       (rst_i),
    .id_ex_i     (id_ex),
    .mem_wb_i    (mem_wb),
    .mem_stall_i (mem_stall),
    .ex_mem_o    (ex_mem)
  );

  memory_stage memory0 (
    .clock                (clock),
    .rst_i                (rst_i),
    .ex_mem_i             (ex_mem),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .mem_stall_o          (mem_stall),
    .mem_wb_o             (mem_wb)
  );

  // Writeback straight from the memory/writeback register
  assign rfile_wr_en_o   = mem_wb.dest_valid;
  assign rfile_wr_addr_o = mem_wb.dest;
  assign rfile_wr_data_o = mem_wb.result;

endmodule

/* tb_pipeline.sv */
`include "pipe_settings.svh"

module tb_pipeline import isa_pkg::*; ();

  localparam int PERIOD     = 100;
  localparam int PROG_LEN   = 32;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 256;
  localparam int NUM_TESTS  = 5;
  localparam int TAIL       = 30;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (PROG_LEN * 20 + 2 * TAIL);

  localparam int MODE_ALU       = 0;
  localparam int MODE_LOAD_USE  = 1;
  localparam int MODE_STORE_LD  = 2;
  localparam int MODE_MIX       = 3;
  localparam int MODE_UNKNOWN   = 4;

  logic                   clock;
  logic                   rst_i;
  logic [`XLEN-1:0]       icache_addr_o;
  logic                   icache_rd_o;
  logic [`XLEN-1:0]       icache_data_i;
  logic                   icache_waitrequest_i;
  logic [`REG_ADDR_W-1:0] rfile_rd_addr1_o;
  logic [`REG_ADDR_W-1:0] rfile_rd_addr2_o;
  logic [`XLEN-1:0]       rfile_rd_data1_i;
  logic [`XLEN-1:0]       rfile_rd_data2_i;
  logic [`XLEN-1:0]       dcache_addr_o;
  logic                   dcache_rd_o;
  logic                   dcache_wr_o;
  logic [`XLEN-1:0]       dcache_wr_data_o;
  logic [`XLEN-1:0]       dcache_data_i;
  logic                   dcache_waitrequest_i;
  logic [`REG_ADDR_W-1:0] rfile_wr_addr_o;
  logic                   rfile_wr_en_o;
  logic [`XLEN-1:0]       rfile_wr_data_o;

  // Memories seen by the DUT and their copies in the model
  logic [`XLEN-1:0] imem [IMEM_WORDS];
  logic [`XLEN-1:0] dmem [DMEM_WORDS];
  logic [`XLEN-1:0] rf [`REG_COUNT];
  logic [`XLEN-1:0] mdmem [DMEM_WORDS];
  logic [`XLEN-1:0] mrf [`REG_COUNT];

  logic [`REG_ADDR_W-1:0] exp_wb_idx [$];
  logic [`XLEN-1:0]       exp_wb_data [$];
  logic [`XLEN-1:0]       exp_st_addr [$];
  logic [`XLEN-1:0]       exp_st_data [$];
  logic [`XLEN-1:0]       exp_ld_addr [$];

  integer seed = 32'h6de82bca;
  int     errors;
  int     checks;
  int     wb_count;
  int     st_count;
  int     i_wait_pct;
  int     d_wait_pct;

  funct_e fn_list [7] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};

  pipeline dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [`REG_ADDR_W-1:0] got,
                           input logic [`REG_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Only r0..r7 so that hazards stay dense
  function automatic logic [`REG_ADDR_W-1:0] rand_reg();
    return `REG_ADDR_W'(rand_below(8));
  endfunction

  function automatic logic [`XLEN-1:0] r_word(input funct_e fn,
                                              input logic [`REG_ADDR_W-1:0] rd,
                                              input logic [`REG_ADDR_W-1:0] rs,
                                              input logic [`REG_ADDR_W-1:0] rt);
    inst_u w;
    w.r_fields.opcode = OPC_RTYPE;
    w.r_fields.rs     = rs;
    w.r_fields.rt     = rt;
    w.r_fields.rd     = rd;
    w.r_fields.pad    = '0;
    w.r_fields.funct  = fn;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] i_word(input opcode_e op,
                                              input logic [`REG_ADDR_W-1:0] rs,
                                              input logic [`REG_ADDR_W-1:0] rt,
                                              input logic [15:0] imm);
    inst_u w;
    w.i_fields.opcode = op;
    w.i_fields.rs     = rs;
    w.i_fields.rt     = rt;
    w.i_fields.imm    = imm;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] alu_instr();
    if (rand_below(8) == 0) begin
      return i_word(OPC_ADDI, rand_reg(), rand_reg(), 16'($random(seed)));
    end
    return r_word(fn_list[rand_below(7)], rand_reg(), rand_reg(), rand_reg());
  endfunction

  // Either a bad major opcode or an R-type with a bad function code
  function automatic logic [`XLEN-1:0] unknown_instr();
    logic [5:0] op;
    if (rand_below(2) == 0) begin
      return {6'h00, 20'($random(seed)), 6'h3f};
    end
    op = 6'($random(seed));
    if (op == OPC_RTYPE || op == OPC_ADDI || op == OPC_LW || op == OPC_SW) begin
      op = 6'h3f;
    end
    return {op, 26'($random(seed))};
  endfunction

  task automatic build_program(input int mode);
    logic [`REG_ADDR_W-1:0] prev_rt;
    logic [`REG_ADDR_W-1:0] prev_rs;
    logic [15:0]            prev_imm;
    int                     pick;
    int                     i;
    prev_rt = '0;
    prev_rs = '0;
    prev_imm = '0;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (i = 0; i < PROG_LEN; i++) begin
      if (mode == MODE_ALU) begin
        imem[i] = alu_instr();
      end else if (mode == MODE_LOAD_USE) begin
        if (i % 2 == 0) begin
          prev_rt = rand_reg();
          imem[i] = i_word(OPC_LW, rand_reg(), prev_rt, 16'($random(seed)));
        end else begin
          imem[i] = r_word(fn_list[rand_below(7)], rand_reg(), prev_rt, rand_reg());
        end
      end else if (mode == MODE_STORE_LD) begin
        if (i % 2 == 0) begin
          prev_rs = rand_reg();
          prev_imm = 16'($random(seed));
          imem[i] = i_word(OPC_SW, prev_rs, rand_reg(), prev_imm);
        end else begin
          imem[i] = i_word(OPC_LW, prev_rs, rand_reg(), prev_imm);
        end
      end else begin
        pick = rand_below(10);
        if (pick == 0 && mode == MODE_UNKNOWN) begin
          imem[i] = unknown_instr();
        end else if (pick == 1 || pick == 2) begin
          imem[i] = i_word(OPC_LW, rand_reg(), rand_reg(), 16'($random(seed)));
        end else if (pick == 3) begin
          imem[i] = i_word(OPC_SW, rand_reg(), rand_reg(), 16'($random(seed)));
        end else begin
          imem[i] = alu_instr();
        end
      end
    end
  endtask

  task automatic init_state();
    int i;
    for (i = 0; i < `REG_COUNT; i++) begin
      rf[i] = (i == 0) ? '0 : $random(seed);
      mrf[i] = rf[i];
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
      mdmem[i] = dmem[i];
    end
  endtask

  // In-order execution of the program, queuing what the DUT must produce
  task automatic run_model();
    inst_u                  w;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       b;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       addr;
    logic [`XLEN-1:0]       val;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   writes;
    int                     i;
    for (i = 0; i < PROG_LEN; i++) begin
      w = imem[i];
      a = mrf[w.i_fields.rs];
      b = mrf[w.i_fields.rt];
      imm = {{(`XLEN-16){w.i_fields.imm[15]}}, w.i_fields.imm};
      addr = a + imm;
      addr[1:0] = 2'b00;
      dest = w.i_fields.rt;
      writes = 1'b1;
      val = '0;
      case (w.r_fields.opcode)
        OPC_RTYPE: begin
          dest = w.r_fields.rd;
          case (w.r_fields.funct)
            FN_ADD:  val = a + b;
            FN_SUB:  val = a - b;
            FN_AND:  val = a & b;
            FN_OR:   val = a | b;
            FN_XOR:  val = a ^ b;
            FN_SLT:  val = ($signed(a) < $signed(b)) ? 1 : 0;
            FN_SLTU: val = (a < b) ? 1 : 0;
            default: writes = 1'b0;
          endcase
        end
        OPC_ADDI: val = a + imm;
        OPC_LW: begin
          val = mdmem[addr[9:2]];
          exp_ld_addr.push_back(addr);
        end
        OPC_SW: begin
          writes = 1'b0;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
          mdmem[addr[9:2]] = b;
        end
        default: writes = 1'b0;
      endcase
      if (writes && dest != '0) begin
        mrf[dest] = val;
        exp_wb_idx.push_back(dest);
        exp_wb_data.push_back(val);
      end
    end
  endtask

  // One falling edge: check outputs, then drive cache and register file inputs
  task automatic service_cycle();
    if (rfile_wr_en_o) begin
      wb_count++;
      if (rfile_wr_addr_o == '0) begin
        $display("Register 0 written with %h", rfile_wr_data_o);
        errors++;
      end else if (exp_wb_idx.size() == 0) begin
        $display("Extra write to register %0d with no result left", rfile_wr_addr_o);
        errors++;
      end else begin
        check_reg("rfile_wr_addr_o", rfile_wr_addr_o, exp_wb_idx.pop_front());
        check_word("rfile_wr_data_o", rfile_wr_data_o, exp_wb_data.pop_front());
      end
      rf[rfile_wr_addr_o] = rfile_wr_data_o;
    end
    icache_waitrequest_i = (rand_below(100) < i_wait_pct);
    dcache_waitrequest_i = (rand_below(100) < d_wait_pct);
    if (dcache_rd_o && !dcache_waitrequest_i) begin
      if (exp_ld_addr.size() == 0) begin
        $display("Extra load from address %h with no load left", dcache_addr_o);
        errors++;
      end else begin
        check_word("dcache_addr_o", dcache_addr_o, exp_ld_addr.pop_front());
      end
    end
    if (dcache_wr_o && !dcache_waitrequest_i) begin
      st_count++;
      if (exp_st_addr.size() == 0) begin
        $display("Extra store to address %h with no store left", dcache_addr_o);
        errors++;
      end else begin
        check_word("dcache_addr_o", dcache_addr_o, exp_st_addr.pop_front());
        check_word("dcache_wr_data_o", dcache_wr_data_o, exp_st_data.pop_front());
      end
      dmem[dcache_addr_o[9:2]] = dcache_wr_data_o;
    end
    dcache_data_i = dmem[dcache_addr_o[9:2]];
    icache_data_i = (icache_addr_o < 4 * IMEM_WORDS) ? imem[icache_addr_o[7:2]] : '0;
    // Write-through comes from updating rf above
    rfile_rd_data1_i = (rfile_rd_addr1_o == '0) ? '0 : rf[rfile_rd_addr1_o];
    rfile_rd_data2_i = (rfile_rd_addr2_o == '0) ? '0 : rf[rfile_rd_addr2_o];
  endtask

  task automatic apply_reset();
    @(negedge clock);
    rst_i = 1'b1;
    icache_waitrequest_i = 1'b0;
    dcache_waitrequest_i = 1'b0;
    repeat (3) @(negedge clock);
    rst_i = 1'b0;
    check_flag("dcache_rd_o", dcache_rd_o, 1'b0);
    check_flag("dcache_wr_o", dcache_wr_o, 1'b0);
    check_flag("rfile_wr_en_o", rfile_wr_en_o, 1'b0);
    service_cycle();
  endtask

  task automatic run_test(input int num, input string name, input int mode,
                          input int ipct, input int dpct);
    int errors_before;
    errors_before = errors;
    wb_count = 0;
    st_count = 0;
    exp_wb_idx.delete();
    exp_wb_data.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_ld_addr.delete();
    build_program(mode);
    init_state();
    run_model();
    i_wait_pct = ipct;
    d_wait_pct = dpct;
    apply_reset();
    while (exp_wb_idx.size() != 0 || exp_st_addr.size() != 0 ||
           exp_ld_addr.size() != 0) begin
      @(negedge clock);
      check_flag("icache_rd_o", icache_rd_o, 1'b1);
      service_cycle();
    end
    // Trailing no-ops must not write anything
    repeat (TAIL) begin
      @(negedge clock);
      check_flag("icache_rd_o", icache_rd_o, 1'b1);
      service_cycle();
    end
    $display("test %0d %s: %0d writebacks, %0d stores, %0d errors",
             num, name, wb_count, st_count, errors - errors_before);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Timeout: pipeline stopped before all expected results arrived");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_i = 1'b1;
    icache_data_i = '0;
    icache_waitrequest_i = 1'b0;
    dcache_data_i = '0;
    dcache_waitrequest_i = 1'b0;
    rfile_rd_data1_i = '0;
    rfile_rd_data2_i = '0;
    errors = 0;
    checks = 0;
    run_test(1, "alu_chain", MODE_ALU, 0, 0);
    run_test(2, "load_use", MODE_LOAD_USE, 0, 0);
    run_test(3, "store_load", MODE_STORE_LD, 0, 0);
    run_test(4, "dcache_wait", MODE_MIX, 0, 40);
    run_test(5, "icache_wait", MODE_UNKNOWN, 40, 20);
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* pipeline.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline.sv
tb_pipeline.sv
